/* design/ddr4_test_pkg.sv */
package ddr4_test_pkg;

  // ********************************************************************
  // App port geometry, scaled to a 128-bit user data path
  // ********************************************************************
  localparam int unsigned APP_ADDR_WIDTH = 28;
  localparam int unsigned APP_DATA_WIDTH = 128;
  localparam int unsigned APP_MASK_WIDTH = 16;

  // Controller command encoding
  localparam logic [2:0] APP_CMD_WRITE = 3'd0;
  localparam logic [2:0] APP_CMD_READ  = 3'd1;

  // Test sequencing limits
  localparam int unsigned ADDR_STEP       = 8;
  localparam int unsigned MAX_OUTSTANDING = 16;
  localparam int unsigned STALL_LIMIT     = 64;
  localparam int unsigned CNT_WIDTH       = 16;
  localparam int unsigned STALL_WIDTH     = $clog2(STALL_LIMIT);
  localparam int unsigned QPTR_WIDTH      = $clog2(MAX_OUTSTANDING);
  localparam int unsigned LANE_WIDTH      = 32;

  typedef struct packed {
    logic                      en;
    logic [2:0]                cmd;
    logic [APP_ADDR_WIDTH-1:0] addr;
  } app_cmd_t;

  typedef struct packed {
    logic                      wren;
    logic                      wend;
    logic [APP_DATA_WIDTH-1:0] data;
    logic [APP_MASK_WIDTH-1:0] mask;
  } app_wdf_t;

  typedef struct packed {
    logic                      valid;
    logic                      rend;
    logic [APP_DATA_WIDTH-1:0] data;
  } app_rd_t;

  typedef struct packed {
    logic                      done;
    logic                      mismatch_err;
    logic                      write_err;
    logic                      read_err;
    logic [CNT_WIDTH-1:0]      mismatch_cnt;
    logic [APP_ADDR_WIDTH-1:0] first_fail_addr;
  } test_status_t;

  // Reader outcome, valid on the rd_done pulse
  typedef struct packed {
    logic                      rd_done;
    logic                      mismatch_err;
    logic                      read_err;
    logic [CNT_WIDTH-1:0]      mismatch_cnt;
    logic [APP_ADDR_WIDTH-1:0] first_fail_addr;
  } check_result_t;

  // Each lane holds address plus lane index, top lane inverted
  function automatic logic [APP_DATA_WIDTH-1:0] pattern_of(
    input logic [APP_ADDR_WIDTH-1:0] addr
  );
    logic [APP_DATA_WIDTH-1:0] pat;
    logic [LANE_WIDTH-1:0]     lane;
    for (int k = 0; k < APP_DATA_WIDTH / LANE_WIDTH; k++) begin
      lane = LANE_WIDTH'(addr) + LANE_WIDTH'(k);
      if (k == APP_DATA_WIDTH / LANE_WIDTH - 1) begin
        lane = ~lane;
      end
      pat[k*LANE_WIDTH +: LANE_WIDTH] = lane;
    end
    return pat;
  endfunction

endpackage

/* design/ddr4_wr_engine.sv */
`timescale 1ns/1ps

module ddr4_wr_engine (
  input  logic                                     c0_ddr4_clk,
  input  logic                                     rst_n_i,
  input  logic                                     run_i,
  input  logic [ddr4_test_pkg::APP_ADDR_WIDTH-1:0] base_addr_i,
  input  logic [ddr4_test_pkg::CNT_WIDTH-1:0]      word_count_i,
  input  logic                                     app_rdy_i,
  input  logic                                     app_wdf_rdy_i,
  output ddr4_test_pkg::app_cmd_t                  cmd_o,
  output ddr4_test_pkg::app_wdf_t                  wdf_o,
  output logic                                     done_o,
  output logic                                     write_err_o
);
  import ddr4_test_pkg::*;

  logic                      busy_q;
  logic                      fin_q;
  logic                      done_q;
  logic                      err_q;
  logic [APP_ADDR_WIDTH-1:0] addr_q;
  logic [CNT_WIDTH-1:0]      cnt_q;
  logic [STALL_WIDTH-1:0]    stall_q;
  logic                      start;
  logic                      issue;
  logic                      accept;

  // fin_q holds off a restart until the controller drops run
  assign start  = run_i && !busy_q && !fin_q;
  assign issue  = busy_q && (cnt_q != word_count_i);
  // Command and data must be taken in the same cycle
  assign accept = issue && app_rdy_i && app_wdf_rdy_i;

  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      fin_q   <= 1'b0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
      cnt_q   <= '0;
      stall_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (!run_i) begin
        busy_q <= 1'b0;
        fin_q  <= 1'b0;
      end else if (start) begin
        busy_q  <= 1'b1;
        cnt_q   <= '0;
        stall_q <= '0;
        err_q   <= 1'b0;
      end else if (busy_q) begin
        if (!issue) begin
          busy_q <= 1'b0;
          fin_q  <= 1'b1;
          done_q <= 1'b1;
        end else if (accept) begin
          cnt_q   <= cnt_q + 1'b1;
          stall_q <= '0;
        end else if (stall_q == STALL_WIDTH'(STALL_LIMIT - 1)) begin
          busy_q <= 1'b0;
          fin_q  <= 1'b1;
          done_q <= 1'b1;
          err_q  <= 1'b1;
        end else begin
          stall_q <= stall_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (start) begin
      addr_q <= base_addr_i;
    end else if (accept) begin
      addr_q <= addr_q + APP_ADDR_WIDTH'(ADDR_STEP);
    end
  end

  always_comb begin
    cmd_o.en    = issue;
    cmd_o.cmd   = APP_CMD_WRITE;
    cmd_o.addr  = addr_q;
    // Single-beat words, all bytes enabled
    wdf_o.wren  = issue;
    wdf_o.wend  = issue;
    wdf_o.data  = pattern_of(addr_q);
    wdf_o.mask  = '0;
  end

  assign done_o      = done_q;
  assign write_err_o = err_q;

  // A stalled word is held, with its command, until taken or timed out
  assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    wdf_o.wren && !(app_rdy_i && app_wdf_rdy_i)
      |=> (wdf_o.wren && cmd_o.en && $stable(cmd_o.addr)) || write_err_o);

endmodule

/* design/ddr4_rd_checker.sv */
`timescale 1ns/1ps

module ddr4_rd_checker (
  input  logic                                     c0_ddr4_clk,
  input  logic                                     rst_n_i,
  input  logic                                     run_i,
  input  logic [ddr4_test_pkg::APP_ADDR_WIDTH-1:0] base_addr_i,
  input  logic [ddr4_test_pkg::CNT_WIDTH-1:0]      word_count_i,
  input  logic                                     app_rdy_i,
  input  ddr4_test_pkg::app_rd_t                   app_rd_i,
  output ddr4_test_pkg::app_cmd_t                  cmd_o,
  output ddr4_test_pkg::check_result_t             result_o
);
  import ddr4_test_pkg::*;

  logic                      busy_q;
  logic                      fin_q;
  logic                      done_q;
  logic                      stray_q;
  logic                      read_err_q;
  logic                      mismatch_err_q;
  logic [CNT_WIDTH-1:0]      mismatch_cnt_q;
  logic [APP_ADDR_WIDTH-1:0] first_fail_q;
  logic [APP_ADDR_WIDTH-1:0] addr_q;
  logic [CNT_WIDTH-1:0]      issued_q;
  logic [STALL_WIDTH-1:0]    stall_q;

  // In-order queue of issued read addresses
  logic [APP_ADDR_WIDTH-1:0] queue_q [MAX_OUTSTANDING];
  logic [QPTR_WIDTH-1:0]     wr_ptr_q;
  logic [QPTR_WIDTH-1:0]     rd_ptr_q;
  logic [QPTR_WIDTH:0]       q_cnt_q;

  logic                      start;
  logic                      cmd_en;
  logic                      push;
  logic                      pop;
  logic                      stray;
  logic                      miss;
  logic                      waiting;
  logic                      stall_hit;
  logic [APP_ADDR_WIDTH-1:0] head_addr;

  assign start     = run_i && !busy_q && !fin_q;
  assign cmd_en    = busy_q && (issued_q != word_count_i) &&
                     (q_cnt_q != (QPTR_WIDTH + 1)'(MAX_OUTSTANDING));
  assign push      = cmd_en && app_rdy_i;
  assign pop       = busy_q && app_rd_i.valid && (q_cnt_q != '0);
  // Any return with no read waiting for it
  assign stray     = app_rd_i.valid && !pop;
  assign head_addr = queue_q[rd_ptr_q];
  assign miss      = pop && (app_rd_i.data != pattern_of(head_addr));
  assign waiting   = (q_cnt_q != '0) || cmd_en;
  assign stall_hit = busy_q && waiting && !push && !app_rd_i.valid &&
                     (stall_q == STALL_WIDTH'(STALL_LIMIT - 1));

  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      busy_q         <= 1'b0;
      fin_q          <= 1'b0;
      done_q         <= 1'b0;
      stray_q        <= 1'b0;
      read_err_q     <= 1'b0;
      mismatch_err_q <= 1'b0;
      mismatch_cnt_q <= '0;
      issued_q       <= '0;
      stall_q        <= '0;
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      q_cnt_q        <= '0;
    end else begin
      done_q <= 1'b0;
      // Strays outside the read phase are charged to the next pass
      if (stray && !busy_q) begin
        stray_q <= 1'b1;
      end
      if (!run_i) begin
        busy_q <= 1'b0;
        fin_q  <= 1'b0;
      end else if (start) begin
        busy_q         <= 1'b1;
        stray_q        <= 1'b0;
        read_err_q     <= stray_q || stray;
        mismatch_err_q <= 1'b0;
        mismatch_cnt_q <= '0;
        issued_q       <= '0;
        stall_q        <= '0;
        wr_ptr_q       <= '0;
        rd_ptr_q       <= '0;
        q_cnt_q        <= '0;
      end else if (busy_q) begin
        if (push) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
          issued_q <= issued_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        case ({push, pop})
          2'b10:   q_cnt_q <= q_cnt_q + 1'b1;
          2'b01:   q_cnt_q <= q_cnt_q - 1'b1;
          default: q_cnt_q <= q_cnt_q;
        endcase
        if (miss) begin
          mismatch_err_q <= 1'b1;
          mismatch_cnt_q <= mismatch_cnt_q + 1'b1;
        end
        if (push || app_rd_i.valid || !waiting) begin
          stall_q <= '0;
        end else begin
          stall_q <= stall_q + 1'b1;
        end
        if (read_err_q || stray || stall_hit) begin
          read_err_q <= 1'b1;
          busy_q     <= 1'b0;
          fin_q      <= 1'b1;
          done_q     <= 1'b1;
        end else if (issued_q == word_count_i && q_cnt_q == '0) begin
          busy_q <= 1'b0;
          fin_q  <= 1'b1;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (push) begin
      queue_q[wr_ptr_q] <= addr_q;
    end
    if (start) begin
      addr_q <= base_addr_i;
    end else if (push) begin
      addr_q <= addr_q + APP_ADDR_WIDTH'(ADDR_STEP);
    end
    if (start) begin
      first_fail_q <= '0;
    end else if (miss && !mismatch_err_q) begin
      first_fail_q <= head_addr;
    end
  end

  always_comb begin
    cmd_o.en                 = cmd_en;
    cmd_o.cmd                = APP_CMD_READ;
    cmd_o.addr               = addr_q;
    result_o.rd_done         = done_q;
    result_o.mismatch_err    = mismatch_err_q;
    result_o.read_err        = read_err_q;
    result_o.mismatch_cnt    = mismatch_cnt_q;
    result_o.first_fail_addr = first_fail_q;
  end

  // Queue count stays within depth and agrees with the pointers
  assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    (q_cnt_q <= (QPTR_WIDTH + 1)'(MAX_OUTSTANDING)) &&
    (QPTR_WIDTH'(wr_ptr_q - rd_ptr_q) == q_cnt_q[QPTR_WIDTH-1:0]));

  // The controller returns one-beat words
  assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    app_rd_i.valid |-> app_rd_i.rend);

endmodule

/* design/ddr4_test_ctrl.sv */
`timescale 1ns/1ps

module ddr4_test_ctrl (
  input  logic                                     c0_ddr4_clk,
  input  logic                                     rst_n_i,
  input  logic                                     init_calib_complete_i,
  input  logic                                     start_i,
  input  logic [ddr4_test_pkg::APP_ADDR_WIDTH-1:0] base_addr_i,
  input  logic [ddr4_test_pkg::CNT_WIDTH-1:0]      word_count_i,
  input  ddr4_test_pkg::app_cmd_t                  wr_cmd_i,
  input  logic                                     wr_done_i,
  input  logic                                     write_err_i,
  input  ddr4_test_pkg::app_cmd_t                  rd_cmd_i,
  input  ddr4_test_pkg::check_result_t             rd_result_i,
  output logic                                     wr_run_o,
  output logic                                     rd_run_o,
  output logic [ddr4_test_pkg::APP_ADDR_WIDTH-1:0] run_base_addr_o,
  output logic [ddr4_test_pkg::CNT_WIDTH-1:0]      run_word_count_o,
  output ddr4_test_pkg::app_cmd_t                  app_cmd_o,
  output ddr4_test_pkg::test_status_t              status_o,
  output logic                                     compare_error_o
);
  import ddr4_test_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    DONE
  } state_t;

  state_t                    state_q;
  test_status_t              status_q;
  logic [APP_ADDR_WIDTH-1:0] base_q;
  logic [CNT_WIDTH-1:0]      count_q;
  logic                      start_ok;

  // Only a calibrated, idle engine takes a start
  assign start_ok = start_i && init_calib_complete_i && (state_q == IDLE);

  // ********************************************************************
  // Phase sequencing
  // ********************************************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      status_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_ok) begin
            status_q <= '0;
            state_q  <= WRITE;
          end
        end
        WRITE: begin
          if (wr_done_i) begin
            status_q.write_err <= write_err_i;
            // No point reading back a region that was not written
            state_q <= write_err_i ? DONE : READ;
          end
        end
        READ: begin
          if (rd_result_i.rd_done) begin
            status_q.mismatch_err    <= rd_result_i.mismatch_err;
            status_q.read_err        <= rd_result_i.read_err;
            status_q.mismatch_cnt    <= rd_result_i.mismatch_cnt;
            status_q.first_fail_addr <= rd_result_i.first_fail_addr;
            state_q                  <= DONE;
          end
        end
        DONE: begin
          status_q.done <= 1'b1;
          state_q       <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Test region is fixed for the whole pass
  always_ff @(posedge c0_ddr4_clk) begin
    if (start_ok) begin
      base_q  <= base_addr_i;
      count_q <= word_count_i;
    end
  end

  assign wr_run_o         = (state_q == WRITE);
  assign rd_run_o         = (state_q == READ);
  assign run_base_addr_o  = base_q;
  assign run_word_count_o = count_q;

  // App command port owner follows the phase
  always_comb begin
    case (state_q)
      WRITE:   app_cmd_o = wr_cmd_i;
      READ:    app_cmd_o = rd_cmd_i;
      default: app_cmd_o = '0;
    endcase
  end

  assign status_o        = status_q;
  assign compare_error_o = status_q.mismatch_err | status_q.write_err | status_q.read_err;

  // The two engines never request the command port together
  assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    !(wr_cmd_i.en && rd_cmd_i.en));

  // Each engine reports completion only inside its own phase
  assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    (!wr_done_i || wr_run_o) && (!rd_result_i.rd_done || rd_run_o));

endmodule

/* design/ddr4_app_tester.sv */
`timescale 1ns/1ps

module ddr4_app_tester (
  input  logic                                     c0_ddr4_clk,
  input  logic                                     rst_n_i,
  input  logic                                     init_calib_complete_i,
  input  logic                                     start_i,
  input  logic [ddr4_test_pkg::APP_ADDR_WIDTH-1:0] base_addr_i,
  input  logic [ddr4_test_pkg::CNT_WIDTH-1:0]      word_count_i,
  input  logic                                     app_rdy_i,
  input  logic                                     app_wdf_rdy_i,
  input  ddr4_test_pkg::app_rd_t                   app_rd_i,
  output ddr4_test_pkg::app_cmd_t                  app_cmd_o,
  output ddr4_test_pkg::app_wdf_t                  app_wdf_o,
  output logic                                     compare_error_o,
  output ddr4_test_pkg::test_status_t              status_o
);
  import ddr4_test_pkg::*;

  app_cmd_t                  wr_cmd;
  app_cmd_t                  rd_cmd;
  check_result_t             rd_result;
  logic                      wr_done;
  logic                      write_err;
  logic                      wr_run;
  logic                      rd_run;
  logic [APP_ADDR_WIDTH-1:0] run_base_addr;
  logic [CNT_WIDTH-1:0]      run_word_count;

  ddr4_test_ctrl ddr4_test_ctrl_inst (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .rst_n_i               (rst_n_i),
    .init_calib_complete_i (init_calib_complete_i),
    .start_i               (start_i),
    .base_addr_i           (base_addr_i),
    .word_count_i          (word_count_i),
    .wr_cmd_i              (wr_cmd),
    .wr_done_i             (wr_done),
    .write_err_i           (write_err),
    .rd_cmd_i              (rd_cmd),
    .rd_result_i           (rd_result),
    .wr_run_o              (wr_run),
    .rd_run_o              (rd_run),
    .run_base_addr_o       (run_base_addr),
    .run_word_count_o      (run_word_count),
    .app_cmd_o             (app_cmd_o),
    .status_o              (status_o),
    .compare_error_o       (compare_error_o)
  );

  // Write data goes to the controller directly
  ddr4_wr_engine ddr4_wr_engine_inst (
    .c0_ddr4_clk   (c0_ddr4_clk),
    .rst_n_i       (rst_n_i),
    .run_i         (wr_run),
    .base_addr_i   (run_base_addr),
    .word_count_i  (run_word_count),
    .app_rdy_i     (app_rdy_i),
    .app_wdf_rdy_i (app_wdf_rdy_i),
    .cmd_o         (wr_cmd),
    .wdf_o         (app_wdf_o),
    .done_o        (wr_done),
    .write_err_o   (write_err)
  );

  ddr4_rd_checker ddr4_rd_checker_inst (
    .c0_ddr4_clk  (c0_ddr4_clk),
    .rst_n_i      (rst_n_i),
    .run_i        (rd_run),
    .base_addr_i  (run_base_addr),
    .word_count_i (run_word_count),
    .app_rdy_i    (app_rdy_i),
    .app_rd_i     (app_rd_i),
    .cmd_o        (rd_cmd),
    .result_o     (rd_result)
  );

endmodule

/* bench/ddr4_app_model.sv */
`timescale 1ns/1ps

module ddr4_app_model (
  input  logic                                     c0_ddr4_clk,
  input  logic                                     clear_i,
  input  int unsigned                              stall_pct_i,
  input  logic                                     corrupt_en_i,
  input  logic [ddr4_test_pkg::APP_ADDR_WIDTH-1:0] corrupt_addr_i,
  input  logic                                     hold_rd_i,
  input  logic                                     spurious_i,
  input  ddr4_test_pkg::app_cmd_t                  app_cmd_i,
  input  ddr4_test_pkg::app_wdf_t                  app_wdf_i,
  output logic                                     app_rdy_o,
  output logic                                     app_wdf_rdy_o,
  output ddr4_test_pkg::app_rd_t                   app_rd_o,
  output int unsigned                              wr_total_o,
  output int unsigned                              wr_dup_o,
  output int unsigned                              wr_bad_o
);
  import ddr4_test_pkg::*;

  // Sparse backing store, one entry per written app word
  logic [APP_DATA_WIDTH-1:0] mem [logic [APP_ADDR_WIDTH-1:0]];
  logic [APP_DATA_WIDTH-1:0] ret_data_q [$];
  int unsigned               ret_due_q [$];
  int unsigned               cycle = 0;
  int unsigned               last_due = 0;
  int unsigned               stall_pct = 0;
  logic                      hold_rd = 1'b0;
  logic                      spurious_pend = 1'b0;
  logic                      app_rdy = 1'b0;
  logic                      app_wdf_rdy = 1'b0;
  app_rd_t                   rd_ret = '0;
  int unsigned               wr_total = 0;
  int unsigned               wr_dup = 0;
  int unsigned               wr_bad = 0;

  // Lanes 0..2 hold address plus lane index, lane 3 the inverse of address plus 3
  function automatic logic [APP_DATA_WIDTH-1:0] expected_pattern(
    input logic [APP_ADDR_WIDTH-1:0] addr
  );
    logic [31:0] a;
    a = {4'b0000, addr};
    return {~(a + 32'd3), a + 32'd2, a + 32'd1, a};
  endfunction

  // Transfers are taken mid-cycle, where both sides have settled
  always @(negedge c0_ddr4_clk) begin
    logic [APP_DATA_WIDTH-1:0] data;
    int unsigned               due;
    cycle     = cycle + 1;
    stall_pct = stall_pct_i;
    hold_rd   = hold_rd_i;
    if (clear_i) begin
      mem.delete();
      ret_data_q.delete();
      ret_due_q.delete();
      last_due      = 0;
      spurious_pend = 1'b0;
      wr_total      = 0;
      wr_dup        = 0;
      wr_bad        = 0;
    end else begin
      if (spurious_i) begin
        spurious_pend = 1'b1;
      end
      if (app_cmd_i.en && app_rdy && app_cmd_i.cmd == APP_CMD_WRITE &&
          app_wdf_i.wren && app_wdf_rdy) begin
        wr_total++;
        if (mem.exists(app_cmd_i.addr)) begin
          wr_dup++;
        end
        if (app_wdf_i.data != expected_pattern(app_cmd_i.addr) ||
            app_wdf_i.mask != '0 || !app_wdf_i.wend) begin
          wr_bad++;
        end
        mem[app_cmd_i.addr] = app_wdf_i.data;
      end
      if (app_cmd_i.en && app_rdy && app_cmd_i.cmd == APP_CMD_READ) begin
        // Random latency, but never overtaking an older read
        due = cycle + $urandom_range(10, 2);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        data = mem.exists(app_cmd_i.addr) ? mem[app_cmd_i.addr] : '0;
        if (corrupt_en_i && app_cmd_i.addr == corrupt_addr_i) begin
          data = data ^ APP_DATA_WIDTH'(1);
        end
        ret_data_q.push_back(data);
        ret_due_q.push_back(due);
      end
    end
  end

  always @(posedge c0_ddr4_clk) begin
    #1;
    app_rdy     = ($urandom_range(99) >= stall_pct);
    app_wdf_rdy = ($urandom_range(99) >= stall_pct);
    rd_ret      = '0;
    if (!hold_rd && ret_due_q.size() != 0 && ret_due_q[0] <= cycle) begin
      rd_ret.valid = 1'b1;
      rd_ret.rend  = 1'b1;
      rd_ret.data  = ret_data_q.pop_front();
      void'(ret_due_q.pop_front());
    end else if (spurious_pend) begin
      // A return that no read asked for
      rd_ret.valid  = 1'b1;
      rd_ret.rend   = 1'b1;
      spurious_pend = 1'b0;
    end
  end

  assign app_rdy_o     = app_rdy;
  assign app_wdf_rdy_o = app_wdf_rdy;
  assign app_rd_o      = rd_ret;
  assign wr_total_o    = wr_total;
  assign wr_dup_o      = wr_dup;
  assign wr_bad_o      = wr_bad;

endmodule

/* bench/ddr4_app_tester_tb.sv */
`timescale 1ns/1ps

module ddr4_app_tester_tb;
  import ddr4_test_pkg::*;

  localparam int unsigned CLK_PERIOD      = 20;
  localparam int unsigned SEED            = 32'h345204d0;
  localparam int unsigned CYCLES_PER_WORD = 40;
  localparam int unsigned TOTAL_WORDS     = 32 + 32 + 64 + 32 + 32 + 32;
  localparam int unsigned MARGIN_CYCLES   = 500;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_WORDS * CYCLES_PER_WORD + MARGIN_CYCLES;

  logic                      c0_ddr4_clk = 1'b0;
  logic                      rst_n = 1'b0;
  logic                      init_calib_complete = 1'b1;
  logic                      start = 1'b0;
  logic [APP_ADDR_WIDTH-1:0] base_addr = '0;
  logic [CNT_WIDTH-1:0]      word_count = '0;
  logic                      app_rdy;
  logic                      app_wdf_rdy;
  app_rd_t                   app_rd;
  app_cmd_t                  app_cmd;
  app_wdf_t                  app_wdf;
  logic                      compare_error;
  test_status_t              status;

  // Model knobs and write statistics
  logic                      clear = 1'b0;
  int unsigned               stall_pct = 0;
  logic                      corrupt_en = 1'b0;
  logic [APP_ADDR_WIDTH-1:0] corrupt_addr = '0;
  logic                      hold_rd = 1'b0;
  logic                      spurious = 1'b0;
  int unsigned               wr_total;
  int unsigned               wr_dup;
  int unsigned               wr_bad;

  int unsigned               checks = 0;
  int unsigned               errors = 0;

  always #(CLK_PERIOD / 2) c0_ddr4_clk = ~c0_ddr4_clk;

  ddr4_app_tester ddr4_app_tester_inst (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .rst_n_i               (rst_n),
    .init_calib_complete_i (init_calib_complete),
    .start_i               (start),
    .base_addr_i           (base_addr),
    .word_count_i          (word_count),
    .app_rdy_i             (app_rdy),
    .app_wdf_rdy_i         (app_wdf_rdy),
    .app_rd_i              (app_rd),
    .app_cmd_o             (app_cmd),
    .app_wdf_o             (app_wdf),
    .compare_error_o       (compare_error),
    .status_o              (status)
  );

  ddr4_app_model ddr4_app_model_inst (
    .c0_ddr4_clk    (c0_ddr4_clk),
    .clear_i        (clear),
    .stall_pct_i    (stall_pct),
    .corrupt_en_i   (corrupt_en),
    .corrupt_addr_i (corrupt_addr),
    .hold_rd_i      (hold_rd),
    .spurious_i     (spurious),
    .app_cmd_i      (app_cmd),
    .app_wdf_i      (app_wdf),
    .app_rdy_o      (app_rdy),
    .app_wdf_rdy_o  (app_wdf_rdy),
    .app_rd_o       (app_rd),
    .wr_total_o     (wr_total),
    .wr_dup_o       (wr_dup),
    .wr_bad_o       (wr_bad)
  );

  // **********************************************************************
  // Compare tasks
  // **********************************************************************
  task automatic check_status(input test_status_t act, input test_status_t exp,
                              input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, act, exp);
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, act, exp);
    end
  endtask

  task automatic check_cmd(input app_cmd_t act, input app_cmd_t exp, input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, act, exp);
    end
  endtask

  task automatic verify_count(input int unsigned act, input int unsigned exp,
                              input string name);
    checks++;
    if (act != exp) begin
      errors++;
      $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, act, exp);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge c0_ddr4_clk);
    #1;
  endtask

  task automatic clear_model();
    clear = 1'b1;
    next_cycle();
    clear = 1'b0;
  endtask

  task automatic run_pass(input logic [APP_ADDR_WIDTH-1:0] base,
                          input logic [CNT_WIDTH-1:0] count);
    app_cmd_t first_cmd;
    first_cmd.en   = 1'b1;
    first_cmd.cmd  = APP_CMD_WRITE;
    first_cmd.addr = base;
    base_addr      = base;
    word_count     = count;
    start          = 1'b1;
    next_cycle();
    start = 1'b0;
    check_status(status, '0, "status_o after start");
    next_cycle();
    check_cmd(app_cmd, first_cmd, "app_cmd_o first command");
    while (!status.done) begin
      next_cycle();
    end
  endtask

  task automatic expect_clean(input int unsigned count);
    test_status_t exp;
    exp      = '0;
    exp.done = 1'b1;
    check_status(status, exp, "status_o");
    check_bit(compare_error, 1'b0, "compare_error_o");
    verify_count(wr_total, count, "model write count");
    verify_count(wr_dup, 0, "model repeated writes");
    verify_count(wr_bad, 0, "model pattern errors");
  endtask

  // **********************************************************************
  // Directed tests
  // **********************************************************************
  task automatic clean_pass();
    clear_model();
    run_pass(28'h000_1000, 16'd32);
    expect_clean(32);
  endtask

  task automatic start_gating();
    test_status_t exp;
    // An ignored start leaves the clean result of the previous pass in place
    exp      = '0;
    exp.done = 1'b1;
    clear_model();
    init_calib_complete = 1'b0;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    repeat (8) begin
      next_cycle();
      check_cmd(app_cmd, '0, "app_cmd_o without calibration");
      check_status(status, exp, "status_o without calibration");
    end
    init_calib_complete = 1'b1;
    run_pass(28'h004_0000, 16'd32);
    expect_clean(32);
  endtask

  task automatic back_pressure();
    clear_model();
    stall_pct = 25;
    run_pass(28'h020_0000, 16'd64);
    stall_pct = 0;
    expect_clean(64);
  endtask

  task automatic data_mismatch();
    test_status_t exp;
    clear_model();
    corrupt_addr = 28'h030_0000 + 28'd5 * ADDR_STEP;
    corrupt_en   = 1'b1;
    run_pass(28'h030_0000, 16'd32);
    corrupt_en           = 1'b0;
    exp                  = '0;
    exp.done             = 1'b1;
    exp.mismatch_err     = 1'b1;
    exp.mismatch_cnt     = 16'd1;
    exp.first_fail_addr  = corrupt_addr;
    check_status(status, exp, "status_o with corrupted word");
    check_bit(compare_error, 1'b1, "compare_error_o with corrupted word");
  endtask

  task automatic read_stall();
    test_status_t exp;
    clear_model();
    hold_rd = 1'b1;
    run_pass(28'h040_0000, 16'd32);
    exp          = '0;
    exp.done     = 1'b1;
    exp.read_err = 1'b1;
    check_status(status, exp, "status_o with held returns");
    check_bit(compare_error, 1'b1, "compare_error_o with held returns");
    // Drop the reads that were never answered
    clear_model();
    hold_rd = 1'b0;
  endtask

  task automatic spurious_return();
    test_status_t exp;
    clear_model();
    spurious = 1'b1;
    next_cycle();
    spurious = 1'b0;
    repeat (3) next_cycle();
    run_pass(28'h050_0000, 16'd32);
    exp          = '0;
    exp.done     = 1'b1;
    exp.read_err = 1'b1;
    check_status(status, exp, "status_o after spurious return");
    check_bit(compare_error, 1'b1, "compare_error_o after spurious return");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge c0_ddr4_clk);
    $display("Timeout: no result after %0d cycles, budget for %0d words",
             WATCHDOG_CYCLES, TOTAL_WORDS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    repeat (2) @(posedge c0_ddr4_clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    clean_pass();
    start_gating();
    back_pressure();
    data_mismatch();
    read_stall();
    spurious_return();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* ddr4_app_tester.f */
design/ddr4_test_pkg.sv
design/ddr4_wr_engine.sv
design/ddr4_rd_checker.sv
design/ddr4_test_ctrl.sv
design/ddr4_app_tester.sv
bench/ddr4_app_model.sv
bench/ddr4_app_tester_tb.sv

/* Bender.yml */
package:
  name: ddr4_app_tester

sources:
  # Synthesizable engine, package first
  - files:
      - design/ddr4_test_pkg.sv
      - design/ddr4_wr_engine.sv
      - design/ddr4_rd_checker.sv
      - design/ddr4_test_ctrl.sv
      - design/ddr4_app_tester.sv

  # Simulation only
  - target: test
    files:
      - bench/ddr4_app_model.sv
      - bench/ddr4_app_tester_tb.sv
